/* hdl/bridge_pkg.sv */
//****************************************
// AXI to AHB bridge shared definitions
// Bus widths, response and transfer codes,
// FSM states and strobe decode helpers
//****************************************
package bridge_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 64;
   localparam int STRB_W     = 8;
   localparam int BYTE_PTR_W = 3;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      SLVERR = 2'd2
   } axi_resp_t;

   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'd0,
      HTRANS_NONSEQ = 2'd2
   } htrans_t;

   typedef logic [2:0] hsize_t;   // log2 of byte count

   typedef enum logic [2:0] {
      IDLE, CMD_RD, DATA_RD, DONE_RD, CMD_WR, DATA_WR, DONE_WR
   } xfer_state_t;

   localparam logic [3:0] HPROT_DATA = 4'h3;   // Data access, privileged

   // Full, half, quarter or single byte at its natural offset
   function automatic logic strb_aligned(logic [STRB_W-1:0] strb);
      logic ok;
      case (strb)
         8'hff, 8'h0f, 8'hf0,
         8'h03, 8'h0c, 8'h30, 8'hc0,
         8'h01, 8'h02, 8'h04, 8'h08,
         8'h10, 8'h20, 8'h40, 8'h80: ok = 1'b1;
         default:                    ok = 1'b0;
      endcase
      return ok;
   endfunction

   function automatic hsize_t strb_size(logic [STRB_W-1:0] strb);
      hsize_t size;
      case (strb)
         8'hff:                      size = 3'd3;
         8'h0f, 8'hf0:               size = 3'd2;
         8'h03, 8'h0c, 8'h30, 8'hc0: size = 3'd1;
         default:                    size = 3'd0;   // Single byte, also split writes
      endcase
      return size;
   endfunction

   // First set strobe bit at or above ptr, top byte when none is left
   function automatic logic [BYTE_PTR_W-1:0] next_byte_ptr(logic [BYTE_PTR_W-1:0] ptr,
                                                           logic [STRB_W-1:0]     strb);
      logic [BYTE_PTR_W-1:0] res;
      logic                  found;
      res   = BYTE_PTR_W'(STRB_W - 1);
      found = 1'b0;
      for (int i = 0; i < STRB_W; i++) begin
         if (!found && strb[i] && (i >= int'(ptr))) begin
            res   = BYTE_PTR_W'(i);
            found = 1'b1;
         end
      end
      return res;
   endfunction

   // Aligned strobe starts at its lowest set bit
   function automatic logic [BYTE_PTR_W-1:0] strb_offset(logic [STRB_W-1:0] strb);
      return next_byte_ptr('0, strb);
   endfunction

endpackage

/* hdl/axi_cmd_front.sv */
//****************************************
// AXI command front end
// Buffers one write (AW and W in any order)
// and offers writes ahead of reads
//****************************************
`timescale 1ns/1ps

module axi_cmd_front import bridge_pkg::*; #(
   parameter int ID_W = 4
) (
   input  logic              bus_clk,
   input  logic              rst,
   input  logic              aw_valid,
   output logic              aw_ready,
   input  logic [ID_W-1:0]   aw_id,
   input  logic [ADDR_W-1:0] aw_addr,
   input  logic [2:0]        aw_size,
   input  logic              w_valid,
   output logic              w_ready,
   input  logic [DATA_W-1:0] w_data,
   input  logic [STRB_W-1:0] w_strb,
   input  logic              ar_valid,
   output logic              ar_ready,
   input  logic [ID_W-1:0]   ar_id,
   input  logic [ADDR_W-1:0] ar_addr,
   input  logic [2:0]        ar_size,
   output logic              cmd_valid,
   input  logic              cmd_ready,
   output logic              cmd_write,
   output logic [ID_W-1:0]   cmd_id,
   output logic [ADDR_W-1:0] cmd_addr,
   output hsize_t            cmd_size,
   output logic [STRB_W-1:0] cmd_strb,
   output logic [DATA_W-1:0] cmd_wdata
);

   logic              aw_full;
   logic              w_full;
   logic [ID_W-1:0]   aw_id_q;
   logic [ADDR_W-1:0] aw_addr_q;
   logic [2:0]        aw_size_q;
   logic [DATA_W-1:0] w_data_q;
   logic [STRB_W-1:0] w_strb_q;
   logic              wr_full;      // Both halves present
   logic              wr_pending;   // Either half present
   logic              wr_take;

   assign aw_ready   = !aw_full;
   assign w_ready    = !w_full;
   assign wr_full    = aw_full & w_full;
   assign wr_pending = aw_full | w_full;
   assign wr_take    = wr_full & cmd_ready;
   assign ar_ready   = !wr_pending & cmd_ready;   // Reads wait behind any write

   // Command mux, write wins
   assign cmd_valid = wr_full | (ar_valid & !wr_pending);
   assign cmd_write = wr_full;
   assign cmd_id    = wr_full ? aw_id_q : ar_id;
   assign cmd_addr  = wr_full ? aw_addr_q : ar_addr;
   assign cmd_size  = wr_full ? aw_size_q : ar_size;
   assign cmd_strb  = wr_full ? w_strb_q : '0;
   assign cmd_wdata = w_data_q;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
      end else begin
         if (aw_valid && aw_ready)
            aw_full <= 1'b1;
         else if (wr_take)
            aw_full <= 1'b0;
         if (w_valid && w_ready)
            w_full <= 1'b1;
         else if (wr_take)
            w_full <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (aw_valid && aw_ready) begin
         aw_id_q   <= aw_id;
         aw_addr_q <= aw_addr;
         aw_size_q <= aw_size;
      end
      if (w_valid && w_ready) begin
         w_data_q <= w_data;
         w_strb_q <= w_strb;
      end
   end

endmodule

/* hdl/ahb_xfer_fsm.sv */
//****************************************
// AHB transfer engine
// Holds one command and runs AHB address
// and data phases, splitting unaligned
// write strobes into byte transfers
//****************************************
`timescale 1ns/1ps

module ahb_xfer_fsm import bridge_pkg::*; #(
   parameter int ID_W = 4
) (
   input  logic              bus_clk,
   input  logic              rst,
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic              cmd_write,
   input  logic [ID_W-1:0]   cmd_id,
   input  logic [ADDR_W-1:0] cmd_addr,
   input  hsize_t            cmd_size,
   input  logic [STRB_W-1:0] cmd_strb,
   input  logic [DATA_W-1:0] cmd_wdata,
   output logic [ADDR_W-1:0] haddr,
   output htrans_t           htrans,
   output hsize_t            hsize,
   output logic              hwrite,
   output logic [DATA_W-1:0] hwdata,
   input  logic [DATA_W-1:0] hrdata,
   input  logic              hready,
   input  logic              hresp,
   output logic              rsp_load,
   output logic              rsp_write,
   output logic [ID_W-1:0]   rsp_id,
   output logic              rsp_error,
   output logic [DATA_W-1:0] rsp_rdata,
   input  logic              rsp_busy
);

   xfer_state_t           state;
   xfer_state_t           state_nxt;

   // Command buffer
   logic [ID_W-1:0]       buf_id;
   logic                  buf_write;
   logic                  buf_split;   // Write goes out byte by byte
   hsize_t                buf_size;
   logic [ADDR_W-1:0]     buf_addr;
   logic [STRB_W-1:0]     buf_strb;
   logic [DATA_W-1:0]     buf_wdata;

   logic [BYTE_PTR_W-1:0] byte_ptr;
   logic [BYTE_PTR_W-1:0] ptr_nxt;
   logic                  cmd_take;
   logic                  last_byte;
   logic                  in_data;

   assign cmd_ready = (state == IDLE);
   assign cmd_take  = cmd_valid & cmd_ready;
   assign in_data   = (state == DATA_RD) || (state == DATA_WR);

   // Next strobe byte above the current one
   assign ptr_nxt   = next_byte_ptr(byte_ptr + 1'b1, buf_strb);
   assign last_byte = !buf_split || (byte_ptr == '1) || !buf_strb[ptr_nxt];

   //****************************************
   // State machine
   //****************************************
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (cmd_take) state_nxt = cmd_write ? CMD_WR : CMD_RD;
         CMD_RD:  if (hready) state_nxt = DATA_RD;
         CMD_WR:  if (hready) state_nxt = DATA_WR;
         DATA_RD: if (hready) state_nxt = DONE_RD;
         DATA_WR: begin
            if (hready)
               state_nxt = (hresp || last_byte) ? DONE_WR : CMD_WR;   // Stop on first error
         end
         DONE_RD, DONE_WR: if (!rsp_busy) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state    <= IDLE;
         byte_ptr <= '0;
      end else begin
         state <= state_nxt;
         if (cmd_take)
            byte_ptr <= next_byte_ptr('0, cmd_strb);   // Lowest strobe byte
         else if ((state == DATA_WR) && hready && !last_byte)
            byte_ptr <= ptr_nxt;
      end
   end

   // Address low bits and size come from the strobe on writes
   always_ff @(posedge bus_clk) begin
      if (cmd_take) begin
         buf_id    <= cmd_id;
         buf_write <= cmd_write;
         buf_strb  <= cmd_strb;
         buf_wdata <= cmd_wdata;
         buf_split <= cmd_write & !strb_aligned(cmd_strb);
         buf_size  <= cmd_write ? strb_size(cmd_strb) : cmd_size;
         if (cmd_write)
            buf_addr <= {cmd_addr[ADDR_W-1:BYTE_PTR_W], strb_offset(cmd_strb)};
         else
            buf_addr <= cmd_addr;
      end
   end

   //****************************************
   // AHB master outputs
   //****************************************
   assign htrans = ((state == CMD_RD) || (state == CMD_WR)) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign hwrite = (state == CMD_WR);
   assign hsize  = buf_size;                    // Zero for split bytes
   assign hwdata = buf_wdata;                   // Byte lanes already in place
   assign haddr  = {buf_addr[ADDR_W-1:BYTE_PTR_W],
                    buf_split ? byte_ptr : buf_addr[BYTE_PTR_W-1:0]};

   // Response hand-off on final or failing data phase
   assign rsp_load  = in_data && hready && ((state == DATA_RD) || hresp || last_byte);
   assign rsp_write = buf_write;
   assign rsp_id    = buf_id;
   assign rsp_error = hresp;
   assign rsp_rdata = hrdata;

   a_addr_aligned: assert property (@(posedge bus_clk) disable iff (rst)
      (htrans == HTRANS_NONSEQ) |-> ((haddr & ((ADDR_W'(1) << hsize) - 1'b1)) == '0))
      else $error("AHB address %h not aligned to hsize %0d", haddr, hsize);

endmodule

/* hdl/axi_resp_gen.sv */
//****************************************
// AXI response generator
// One-entry B/R response buffer
//****************************************
`timescale 1ns/1ps

module axi_resp_gen import bridge_pkg::*; #(
   parameter int ID_W = 4
) (
   input  logic              bus_clk,
   input  logic              rst,
   input  logic              rsp_load,
   input  logic              rsp_write,
   input  logic [ID_W-1:0]   rsp_id,
   input  logic              rsp_error,
   input  logic [DATA_W-1:0] rsp_rdata,
   output logic              rsp_busy,
   output logic              b_valid,
   input  logic              b_ready,
   output logic [ID_W-1:0]   b_id,
   output axi_resp_t         b_resp,
   output logic              r_valid,
   input  logic              r_ready,
   output logic [ID_W-1:0]   r_id,
   output logic [DATA_W-1:0] r_data,
   output axi_resp_t         r_resp
);

   logic              rsp_valid;
   logic              rsp_write_q;
   logic              rsp_error_q;
   logic [ID_W-1:0]   rsp_id_q;
   logic [DATA_W-1:0] rsp_rdata_q;
   logic              rsp_done;

   assign rsp_done = (b_valid & b_ready) | (r_valid & r_ready);
   assign rsp_busy = rsp_valid;

   always_ff @(posedge bus_clk) begin
      if (rst)
         rsp_valid <= 1'b0;
      else if (rsp_load)
         rsp_valid <= 1'b1;
      else if (rsp_done)
         rsp_valid <= 1'b0;
   end

   always_ff @(posedge bus_clk) begin
      if (rsp_load) begin
         rsp_write_q <= rsp_write;
         rsp_error_q <= rsp_error;
         rsp_id_q    <= rsp_id;
         rsp_rdata_q <= rsp_error ? '0 : rsp_rdata;   // Error reads return zero
      end
   end

   assign b_valid = rsp_valid & rsp_write_q;
   assign b_id    = rsp_id_q;
   assign b_resp  = rsp_error_q ? SLVERR : OKAY;
   assign r_valid = rsp_valid & !rsp_write_q;
   assign r_id    = rsp_id_q;
   assign r_data  = rsp_rdata_q;
   assign r_resp  = rsp_error_q ? SLVERR : OKAY;

   // Stalled response must hold
   a_b_stable: assert property (@(posedge bus_clk) disable iff (rst)
      (b_valid && !b_ready) |=> (b_valid && $stable(b_id) && $stable(b_resp)))
      else $error("B response changed while stalled");

   a_r_stable: assert property (@(posedge bus_clk) disable iff (rst)
      (r_valid && !r_ready) |=> (r_valid && $stable(r_id) && $stable(r_resp)
                                 && $stable(r_data)))
      else $error("R response changed while stalled");

endmodule

/* hdl/axi_ahb_bridge.sv */
//****************************************
// AXI4 to AHB-Lite bridge top level
// Single-beat AXI slave, AHB-Lite master
//****************************************
`timescale 1ns/1ps

module axi_ahb_bridge import bridge_pkg::*; #(
   parameter int ID_W = 4
) (
   input  logic              bus_clk,
   input  logic              rst,
   // AXI write channels
   input  logic              aw_valid,
   output logic              aw_ready,
   input  logic [ID_W-1:0]   aw_id,
   input  logic [ADDR_W-1:0] aw_addr,
   input  logic [2:0]        aw_size,
   input  logic              w_valid,
   output logic              w_ready,
   input  logic [DATA_W-1:0] w_data,
   input  logic [STRB_W-1:0] w_strb,
   output logic              b_valid,
   input  logic              b_ready,
   output logic [ID_W-1:0]   b_id,
   output axi_resp_t         b_resp,
   // AXI read channels
   input  logic              ar_valid,
   output logic              ar_ready,
   input  logic [ID_W-1:0]   ar_id,
   input  logic [ADDR_W-1:0] ar_addr,
   input  logic [2:0]        ar_size,
   output logic              r_valid,
   input  logic              r_ready,
   output logic [ID_W-1:0]   r_id,
   output logic [DATA_W-1:0] r_data,
   output axi_resp_t         r_resp,
   output logic              r_last,
   // AHB-Lite master
   output logic [ADDR_W-1:0] haddr,
   output htrans_t           htrans,
   output hsize_t            hsize,
   output logic              hwrite,
   output logic [DATA_W-1:0] hwdata,
   output logic [2:0]        hburst,
   output logic [3:0]        hprot,
   output logic              hmastlock,
   input  logic [DATA_W-1:0] hrdata,
   input  logic              hready,
   input  logic              hresp
);

   // Front end to transfer engine
   logic              cmd_valid;
   logic              cmd_ready;
   logic              cmd_write;
   logic [ID_W-1:0]   cmd_id;
   logic [ADDR_W-1:0] cmd_addr;
   hsize_t            cmd_size;
   logic [STRB_W-1:0] cmd_strb;
   logic [DATA_W-1:0] cmd_wdata;

   // Transfer engine to response buffer
   logic              rsp_load;
   logic              rsp_write;
   logic [ID_W-1:0]   rsp_id;
   logic              rsp_error;
   logic [DATA_W-1:0] rsp_rdata;
   logic              rsp_busy;

   assign hburst    = 3'b000;       // Single transfers only
   assign hmastlock = 1'b0;
   assign hprot     = HPROT_DATA;
   assign r_last    = 1'b1;

   axi_cmd_front #(.ID_W(ID_W)) cmd_front_i (
      .bus_clk, .rst,
      .aw_valid, .aw_ready, .aw_id, .aw_addr, .aw_size,
      .w_valid, .w_ready, .w_data, .w_strb,
      .ar_valid, .ar_ready, .ar_id, .ar_addr, .ar_size,
      .cmd_valid, .cmd_ready, .cmd_write, .cmd_id,
      .cmd_addr, .cmd_size, .cmd_strb, .cmd_wdata
   );

   ahb_xfer_fsm #(.ID_W(ID_W)) xfer_fsm_i (
      .bus_clk, .rst,
      .cmd_valid, .cmd_ready, .cmd_write, .cmd_id,
      .cmd_addr, .cmd_size, .cmd_strb, .cmd_wdata,
      .haddr, .htrans, .hsize, .hwrite, .hwdata,
      .hrdata, .hready, .hresp,
      .rsp_load, .rsp_write, .rsp_id, .rsp_error, .rsp_rdata, .rsp_busy
   );

   axi_resp_gen #(.ID_W(ID_W)) resp_gen_i (
      .bus_clk, .rst,
      .rsp_load, .rsp_write, .rsp_id, .rsp_error, .rsp_rdata, .rsp_busy,
      .b_valid, .b_ready, .b_id, .b_resp,
      .r_valid, .r_ready, .r_id, .r_data, .r_resp
   );

endmodule

/* verif/ahb_slave_model.sv */
//****************************************
// AHB-Lite memory slave model
// Random wait states, two-cycle ERROR
// response at and above the error base
//****************************************
`timescale 1ns/1ps

module ahb_slave_model import bridge_pkg::*; #(
   parameter logic [ADDR_W-1:0] ERR_BASE  = 32'h0000_1000,
   parameter int                MEM_WORDS = 256
) (
   input  logic              bus_clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] haddr,
   input  htrans_t           htrans,
   input  hsize_t            hsize,
   input  logic              hwrite,
   input  logic [DATA_W-1:0] hwdata,
   output logic [DATA_W-1:0] hrdata,
   output logic              hready,
   output logic              hresp
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [DATA_W-1:0] mem [MEM_WORDS];
   logic              dp_active;      // Data phase in progress
   logic              dp_err;
   logic              dp_write;
   logic              err_first;      // First ERROR cycle, hready low
   logic [ADDR_W-1:0] dp_addr;
   hsize_t            dp_size;
   logic [1:0]        waits;
   int                seed;

   initial begin
      seed = 32'hd93d_9018;
   end

   assign hready = !dp_active || ((waits == 2'd0) && !(dp_err && err_first));
   assign hresp  = dp_active && dp_err && (waits == 2'd0);
   assign hrdata = (dp_active && !dp_err) ? mem[dp_addr[3 +: IDX_W]] : '0;

   always @(posedge bus_clk) begin
      int lo;
      int nbytes;
      lo     = int'(dp_addr[2:0]);
      nbytes = 1 << dp_size;
      if (rst) begin
         dp_active <= 1'b0;
         dp_err    <= 1'b0;
         err_first <= 1'b0;
         waits     <= 2'd0;
         for (int i = 0; i < MEM_WORDS; i++)   // Pattern from the word address
            mem[i] <= {ADDR_W'(i * 8) ^ 32'h5a5a_0000, ~ADDR_W'(i * 8)};
      end else begin
         if (dp_active) begin
            if (waits != 2'd0)
               waits <= waits - 2'd1;
            else if (dp_err && err_first)
               err_first <= 1'b0;
            else begin
               if (dp_write && !dp_err) begin
                  for (int b = 0; b < STRB_W; b++)
                     if (b >= lo && b < lo + nbytes)
                        mem[dp_addr[3 +: IDX_W]][8*b +: 8] <= hwdata[8*b +: 8];
               end
               dp_active <= 1'b0;
            end
         end
         if ((htrans == HTRANS_NONSEQ) && hready) begin   // Address phase accepted
            dp_active <= 1'b1;
            dp_addr   <= haddr;
            dp_size   <= hsize;
            dp_write  <= hwrite;
            dp_err    <= (haddr >= ERR_BASE);
            err_first <= 1'b1;
            waits     <= 2'($unsigned($random(seed)) % 3);
         end
      end
   end

endmodule

/* verif/tb_axi_ahb_bridge.sv */
//****************************************
// AXI to AHB bridge testbench
// AXI stimulus, reference memory and
// concurrent assertions on both buses
//****************************************
`timescale 1ns/1ps

module tb_axi_ahb_bridge import bridge_pkg::*; ();

   localparam int                ID_W      = 4;
   localparam logic [ADDR_W-1:0] ERR_BASE  = 32'h0000_1000;
   localparam int                MEM_WORDS = 256;
   localparam int                TIMEOUT   = 200;

   logic bus_clk;
   logic rst;
   logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   logic ar_valid, ar_ready, r_valid, r_ready, r_last;
   logic [ID_W-1:0]   aw_id, ar_id, b_id, r_id;
   logic [ADDR_W-1:0] aw_addr, ar_addr, haddr;
   logic [2:0]        aw_size, ar_size, hburst;
   logic [DATA_W-1:0] w_data, r_data, hwdata, hrdata;
   logic [STRB_W-1:0] w_strb;
   axi_resp_t         b_resp, r_resp;
   htrans_t           htrans;
   hsize_t            hsize;
   logic              hwrite, hmastlock, hready, hresp;
   logic [3:0]        hprot;

   logic [DATA_W-1:0] ref_mem [MEM_WORDS];   // Reference memory
   int                seed;
   logic              bp_on;
   int                wr_issued, rd_issued;
   int                b_count   = 0;
   int                r_count   = 0;
   int                phase_cnt = 0;

   // Expected values of the write and read in flight
   logic [ADDR_W-1:0] exp_wr_addr, exp_rd_addr;
   logic [STRB_W-1:0] exp_wr_strb;
   logic              exp_wr_split;
   hsize_t            exp_wr_size;
   logic [2:0]        exp_wr_off, exp_lane;
   int                exp_phases, wr_phase_base;
   logic [ID_W-1:0]   exp_b_id, exp_r_id;
   axi_resp_t         exp_b_resp, exp_r_resp;
   logic [DATA_W-1:0] exp_r_data;

   axi_ahb_bridge #(.ID_W(ID_W)) dut_i (.*);

   ahb_slave_model #(.ERR_BASE(ERR_BASE), .MEM_WORDS(MEM_WORDS)) ahb_mem_i (
      .bus_clk, .rst, .haddr, .htrans, .hsize, .hwrite, .hwdata,
      .hrdata, .hready, .hresp
   );

   always #10 bus_clk = ~bus_clk;

   //****************************************
   // Strobe rules and reporting
   //****************************************
   function automatic logic natural_strb(logic [7:0] s, output int size, output int off);
      logic ok;
      ok   = 1'b0;
      size = 0;
      off  = 0;
      for (int sz = 0; sz < 4; sz++)
         for (int o = 0; o < 8; o += (1 << sz))
            if (s == 8'(((1 << (1 << sz)) - 1) << o)) begin
               ok   = 1'b1;
               size = sz;
               off  = o;
            end
      return ok;
   endfunction

   function automatic logic [2:0] nth_set_bit(logic [7:0] s, int k);
      int         seen;
      logic [2:0] pos;
      seen = 0;
      pos  = 3'd0;
      for (int i = 0; i < 8; i++)
         if (s[i]) begin
            if (seen == k) pos = 3'(i);
            seen++;
         end
      return pos;
   endfunction

   always_comb exp_lane = exp_wr_split ? nth_set_bit(exp_wr_strb, phase_cnt - wr_phase_base)
                                       : exp_wr_off;

   task automatic report_check(string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic timeout_fail(string what);
      $display("Timeout at %0t ns: %s never arrived", $time, what);
      $display("sim failed");
      $fatal(1);
   endtask

   always @(posedge bus_clk) begin
      if ((htrans == HTRANS_NONSEQ) && hready) phase_cnt <= phase_cnt + 1;
      if (b_valid && b_ready) b_count <= b_count + 1;
      if (r_valid && r_ready) r_count <= r_count + 1;
   end

   always @(posedge bus_clk) begin   // Random B/R back-pressure
      #1;
      b_ready = bp_on ? 1'($random(seed)) : 1'b1;
      r_ready = bp_on ? 1'($random(seed)) : 1'b1;
   end

   //****************************************
   // Checks
   //****************************************
   a_wr_phase: assert property (@(posedge bus_clk) disable iff (rst)
      (htrans == HTRANS_NONSEQ && hready && hwrite) |->
         (haddr == {exp_wr_addr[ADDR_W-1:3], exp_lane} && hsize == exp_wr_size
          && (phase_cnt - wr_phase_base) < exp_phases))
      else report_check("write address phase has wrong address, size or count");

   a_rd_phase: assert property (@(posedge bus_clk) disable iff (rst)
      (htrans == HTRANS_NONSEQ && hready && !hwrite) |-> (haddr == exp_rd_addr && hsize == 3'd3))
      else report_check("read address phase has wrong address or size");

   // Single transfer, data access, privileged, never locked
   a_ahb_fixed: assert property (@(posedge bus_clk) disable iff (rst)
      (htrans == HTRANS_NONSEQ) |-> (hburst == 3'b000 && hprot == 4'h3 && !hmastlock))
      else report_check("address phase has wrong hburst, hprot or hmastlock");

   // An error write ends after its first address phase
   a_b_resp: assert property (@(posedge bus_clk) disable iff (rst)
      (b_valid && b_ready) |-> (b_id == exp_b_id && b_resp == exp_b_resp && b_count < wr_issued
         && (phase_cnt - wr_phase_base) == ((exp_b_resp == OKAY) ? exp_phases : 1)))
      else report_check("B response has wrong ID, code or phase count, or is extra");

   a_r_resp: assert property (@(posedge bus_clk) disable iff (rst)
      (r_valid && r_ready) |-> (r_id == exp_r_id && r_resp == exp_r_resp && r_last
         && r_data == exp_r_data && r_count < rd_issued && b_count == wr_issued))
      else report_check("R response has wrong ID, code or data, or is out of order");

   a_b_hold: assert property (@(posedge bus_clk) disable iff (rst)
      (b_valid && !b_ready) |=> (b_valid && $stable(b_id) && $stable(b_resp)))
      else report_check("stalled B response changed");

   a_r_hold: assert property (@(posedge bus_clk) disable iff (rst)
      (r_valid && !r_ready) |=> (r_valid && $stable(r_id) && $stable(r_data) && $stable(r_resp)))
      else report_check("stalled R response changed");

   //****************************************
   // AXI channel tasks
   //****************************************
   task automatic send_aw(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr);
      int n;
      n        = 0;
      aw_id    = id;
      aw_addr  = addr;
      aw_valid = 1'b1;
      while (!aw_ready) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT)
            timeout_fail("aw_ready for the write address");
      end
      @(posedge bus_clk);
      #1;
      aw_valid = 1'b0;
   endtask

   task automatic send_w(logic [DATA_W-1:0] data, logic [STRB_W-1:0] strb);
      int n;
      n       = 0;
      w_data  = data;
      w_strb  = strb;
      w_valid = 1'b1;
      while (!w_ready) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT)
            timeout_fail("w_ready for the write data");
      end
      @(posedge bus_clk);
      #1;
      w_valid = 1'b0;
   endtask

   task automatic send_ar(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr);
      int n;
      n        = 0;
      ar_id    = id;
      ar_addr  = addr;
      ar_valid = 1'b1;
      while (!ar_ready) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT)
            timeout_fail("ar_ready for the read address");
      end
      @(posedge bus_clk);
      #1;
      ar_valid = 1'b0;
   endtask

   task automatic wait_b(int start);
      int n;
      n = 0;
      while (b_count == start) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT)
            timeout_fail("B write response");
      end
   endtask

   task automatic wait_r(int start);
      int n;
      n = 0;
      while (r_count == start) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT)
            timeout_fail("R read response");
      end
   endtask

   // Sets expectations and merges the write into the reference memory
   task automatic prepare_write(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr,
                                logic [DATA_W-1:0] data, logic [STRB_W-1:0] strb);
      int   sz, off;
      logic nat;
      nat           = natural_strb(strb, sz, off);
      exp_wr_addr   = addr;
      exp_wr_strb   = strb;
      exp_wr_split  = !nat;
      exp_wr_size   = nat ? 3'(sz) : 3'd0;
      exp_wr_off    = 3'(off);
      exp_phases    = nat ? 1 : $countones(strb);
      wr_phase_base = phase_cnt;
      exp_b_id      = id;
      exp_b_resp    = (addr >= ERR_BASE) ? SLVERR : OKAY;
      if (addr < ERR_BASE)
         for (int b = 0; b < STRB_W; b++)
            if (strb[b]) ref_mem[addr[10:3]][8*b +: 8] = data[8*b +: 8];
      wr_issued++;
   endtask

   task automatic prepare_read(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr);
      exp_r_id    = id;
      exp_rd_addr = addr;
      exp_r_resp  = (addr >= ERR_BASE) ? SLVERR : OKAY;
      exp_r_data  = (addr >= ERR_BASE) ? '0 : ref_mem[addr[10:3]];
      rd_issued++;
   endtask

   task automatic do_write(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr,
                           logic [DATA_W-1:0] data, logic [STRB_W-1:0] strb);
      int start;
      start = b_count;
      prepare_write(id, addr, data, strb);
      fork
         send_aw(id, addr);
         send_w(data, strb);
      join
      wait_b(start);
   endtask

   task automatic do_read(logic [ID_W-1:0] id, logic [ADDR_W-1:0] addr);
      int start;
      start = r_count;
      prepare_read(id, addr);
      send_ar(id, addr);
      wait_r(start);
   endtask

   //****************************************
   // Test sequence
   //****************************************
   initial begin
      int                bs, rs;
      logic [DATA_W-1:0] wd;
      seed      = 32'hd93d_9018;
      bus_clk   = 1'b0;
      rst       = 1'b1;
      bp_on     = 1'b0;
      wr_issued = 0;
      rd_issued = 0;
      {aw_valid, w_valid, ar_valid} = 3'b000;
      {aw_id, ar_id, aw_addr, ar_addr} = '0;
      aw_size = 3'd3;
      ar_size = 3'd3;
      w_data  = '0;
      w_strb  = '0;
      b_ready = 1'b1;
      r_ready = 1'b1;
      for (int i = 0; i < MEM_WORDS; i++)
         ref_mem[i] = {ADDR_W'(i * 8) ^ 32'h5a5a_0000, ~ADDR_W'(i * 8)};
      repeat (4) @(posedge bus_clk);
      #1 rst = 1'b0;

      do_write(4'd1, 32'h100, {$random(seed), $random(seed)}, 8'hff);   // Full write, read back
      do_read(4'd2, 32'h100);
      do_write(4'd3, 32'h108, {$random(seed), $random(seed)}, 8'hf0);   // Aligned partials
      do_write(4'd4, 32'h108, {$random(seed), $random(seed)}, 8'h0c);
      do_write(4'd5, 32'h108, {$random(seed), $random(seed)}, 8'h40);
      do_read(4'd6, 32'h108);
      do_write(4'd7, 32'h110, {$random(seed), $random(seed)}, 8'ha5);   // Scattered strobes
      do_write(4'd8, 32'h110, {$random(seed), $random(seed)}, 8'h81);
      do_read(4'd9, 32'h110);

      do_write(4'ha, 32'h1008, {$random(seed), $random(seed)}, 8'hff);  // Error region
      do_write(4'hb, 32'h1010, {$random(seed), $random(seed)}, 8'h5a);
      do_read(4'hc, 32'h1008);
      do_write(4'hd, 32'h200, {$random(seed), $random(seed)}, 8'hff);
      do_read(4'he, 32'h200);

      bp_on = 1'b1;                                                      // Back-pressure
      for (int i = 0; i < 12; i++) begin
         do_write(4'(i), {21'd0, 8'($random(seed)), 3'd0}, {$random(seed), $random(seed)},
                  8'($random(seed)) | 8'h01);
         do_read(4'(i + 1), exp_wr_addr);
      end
      bp_on = 1'b0;

      // W before AW, then AW before W with a read queued behind it
      bs = b_count;
      wd = {$random(seed), $random(seed)};
      prepare_write(4'h3, 32'h300, wd, 8'h3c);
      send_w(wd, 8'h3c);
      send_aw(4'h3, 32'h300);
      wait_b(bs);
      do_read(4'h4, 32'h300);
      bs = b_count;
      rs = r_count;
      prepare_write(4'h5, 32'h308, 64'h0123_4567_89ab_cdef, 8'hff);
      prepare_read(4'h6, 32'h308);
      fork
         send_aw(4'h5, 32'h308);
         begin
            repeat (3) @(posedge bus_clk);
            #1 send_w(64'h0123_4567_89ab_cdef, 8'hff);
         end
         begin
            @(posedge bus_clk);
            #1 send_ar(4'h6, 32'h308);
         end
      join
      wait_b(bs);
      wait_r(rs);

      repeat (5) @(posedge bus_clk);
      if (b_count == wr_issued && r_count == rd_issued) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("Response count mismatch: %0d of %0d B, %0d of %0d R",
                  b_count, wr_issued, r_count, rd_issued);
         $display("sim failed");
         $fatal(1);
      end
   end

endmodule

/* tb.f */
hdl/bridge_pkg.sv
hdl/axi_cmd_front.sv
hdl/ahb_xfer_fsm.sv
hdl/axi_resp_gen.sv
hdl/axi_ahb_bridge.sv
verif/ahb_slave_model.sv
verif/tb_axi_ahb_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_axi_ahb_bridge \
   -o tb_sim > sim.log 2>&1 && ./obj_dir/tb_sim >> sim.log 2>&1
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
